// ==== all.f ====
+incdir+logic
logic/uncore_msg_pkg.sv
logic/uncore_map_pkg.sv
logic/two_fifo.sv
logic/cmd_router.sv
logic/local_slave.sv
logic/resp_router.sv
logic/uncore_top.sv
verification/uncore_assertions.sv
verification/uncore_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the uncore testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f all.f --top-module uncore_tb \
  --Mdir "$build_dir" -o uncore_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/uncore_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test passed" "$log_file"; then
  exit 0
fi
exit 1

// ==== verification/uncore_tb.sv ====
`timescale 1ns/1ns
`include "uncore_cfg.svh"

module uncore_tb
  import uncore_msg_pkg::*;
  import uncore_map_pkg::*;
  ();

  localparam int num_req_lp = `UNCORE_NUM_REQ;
  localparam int cmds_lp = 60;
  localparam int timeout_cycles_lp = num_req_lp * cmds_lp * 40;
  localparam data_t dev_key_lp = 64'h5a5a_0f0f_c3c3_9696;

  // Expected message together with the destination its address class implies
  typedef struct packed
  {
    dest_e dest;
    mem_msg_s msg;
  } exp_msg_s;

  logic clk_i = 1'b0;
  logic reset_i;
  mem_msg_s [num_req_lp-1:0] req_cmd_i;
  logic [num_req_lp-1:0] req_cmd_v_i, req_cmd_ready_o;
  mem_msg_s [num_req_lp-1:0] req_resp_o;
  logic [num_req_lp-1:0] req_resp_v_o, req_resp_yumi_i;
  mem_msg_s io_cmd_o, io_resp_i, mem_cmd_o, mem_resp_i;
  logic io_cmd_v_o, io_cmd_ready_i, io_resp_v_i, io_resp_yumi_o;
  logic mem_cmd_v_o, mem_cmd_ready_i, mem_resp_v_i, mem_resp_yumi_o;

  integer seed;
  exp_msg_s cmd_q [num_req_lp][$];
  exp_msg_s resp_q [num_req_lp][$];
  mem_msg_s io_q [$];
  mem_msg_s mem_q [$];
  data_t cfg_model [`UNCORE_CFG_REGS];
  dest_e pend_dest [num_req_lp];
  int issued [num_req_lp];
  int hold_cnt [num_req_lp];
  int io_stall, received;
  logic cfg_busy, io_taken, mem_taken;
  logic [num_req_lp-1:0] cmd_acc;

  uncore_top u_uncore_top (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  function automatic mem_msg_s dev_resp(input mem_msg_s c);
    mem_msg_s m;
    m = c;
    m.data = data_t'(c.addr) ^ dev_key_lp;
    return m;
  endfunction

  task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  // Builds one command of a random address class and presents it
  task automatic make_cmd(input int r);
    logic [31:0] a, b, c;
    mem_msg_s m;
    a = next_rand();
    b = next_rand();
    c = next_rand();
    m.op = msg_op_e'(a[4]);
    m.id = req_id_t'(r);
    m.data = {b, c};
    m.addr = {8'h00, 1'b0, b[30:0]};
    // Only one configuration access is in flight at a time
    if ((a[10:8] == 3'd0 || a[10:8] == 3'd5) && !cfg_busy)
    begin
      m.addr[`UNCORE_DEV_LSB +: 4] = DEV_CFG;
      pend_dest[r] = DEST_CFG;
      cfg_busy = 1'b1;
    end
    else if (a[10:8] == 3'd2 || a[10:8] == 3'd7)
    begin
      m.addr[`UNCORE_DEV_LSB +: 4] = (c[1:0] == 2'd0) ? DEV_BOOT :
                                     (c[1:0] == 2'd1) ? DEV_HOST : DEV_SD;
      pend_dest[r] = DEST_IO;
    end
    else if (a[10:8] == 3'd3)
    begin
      m.addr[`UNCORE_PADDR_W-1 -: `UNCORE_DID_W] = {c[6:1], 1'b1};
      pend_dest[r] = DEST_IO;
    end
    else if (a[10:8] == 3'd4)
    begin
      if (c[0])
        m.addr[31] = 1'b1;
      else
        m.addr[`UNCORE_DEV_LSB +: 4] = DEV_CACHE;
      pend_dest[r] = DEST_MEM;
    end
    else
    begin
      m.addr[`UNCORE_DEV_LSB +: 4] = c[0] ? 4'(DEV_CLINT) : {1'b1, c[3:1]};
      pend_dest[r] = DEST_LOOP;
    end
    req_cmd_i[r] = m;
    req_cmd_v_i[r] = 1'b1;
    issued[r] = issued[r] + 1;
  endtask

  task automatic accept_cmd(input int r);
    mem_msg_s m, e;
    logic [2:0] idx;
    m = req_cmd_i[r];
    e = m;
    idx = m.addr[5:3];
    case (pend_dest[r])
      DEST_CFG:
      begin
        e.data = (m.op == MSG_RD) ? cfg_model[idx] : '0;
        if (m.op == MSG_WR)
          cfg_model[idx] = m.data;
      end
      DEST_LOOP: e.data = '0;
      default: e.data = data_t'(m.addr) ^ dev_key_lp;
    endcase
    cmd_q[r].push_back({pend_dest[r], m});
    resp_q[r].push_back({pend_dest[r], e});
  endtask

  task automatic check_dispatch(input string port, input mem_msg_s m, input dest_e d);
    exp_msg_s e;
    int r;
    r = int'(m.id);
    if (r >= num_req_lp)
      abort_run($sformatf("%s carried a command with unknown requester id %0d", port, r));
    // Local commands queued ahead of this one have already been dispatched
    while (cmd_q[r].size() > 0 && cmd_q[r][0].dest inside {DEST_CFG, DEST_LOOP})
      void'(cmd_q[r].pop_front());
    if (cmd_q[r].size() == 0)
      abort_run($sformatf("%s sent a command that no requester issued", port));
    e = cmd_q[r].pop_front();
    check_eq({port, " destination"}, 128'(d), 128'(e.dest));
    check_eq(port, 128'(m), 128'(e.msg));
  endtask

  task automatic check_resp(input int r);
    mem_msg_s m;
    int hit;
    m = req_resp_o[r];
    hit = -1;
    for (int i = 0; i < resp_q[r].size(); i++)
      if (hit < 0 && resp_q[r][i].msg.addr == m.addr && resp_q[r][i].msg.op == m.op)
        hit = i;
    if (hit < 0)
      abort_run($sformatf("Requester %0d got an unexpected response for address 0x%0h",
                          r, m.addr));
    check_eq($sformatf("req_resp_o[%0d]", r), 128'(m), 128'(resp_q[r][hit].msg));
    if (resp_q[r][hit].dest == DEST_CFG)
      cfg_busy = 1'b0;
    resp_q[r].delete(hit);
    received = received + 1;
  endtask

  task automatic drive_inputs();
    logic [31:0] a;
    for (int r = 0; r < num_req_lp; r++)
    begin
      a = next_rand();
      if (cmd_acc[r])
        req_cmd_v_i[r] = 1'b0;
      if (!req_cmd_v_i[r] && issued[r] < cmds_lp && a[0])
        make_cmd(r);
      // Stretches where the requester holds back its yumi
      if (hold_cnt[r] > 0)
        hold_cnt[r] = hold_cnt[r] - 1;
      else if (a[6:2] == 5'd0)
        hold_cnt[r] = 4 + int'(a[11:8]);
      req_resp_yumi_i[r] = req_resp_v_o[r] && (hold_cnt[r] == 0) && a[12];
    end
    a = next_rand();
    if (io_stall > 0)
      io_stall = io_stall - 1;
    else if (a[5:0] == 6'd0)
      io_stall = 6 + int'(a[11:8]);
    io_cmd_ready_i = (io_stall == 0) && (a[13:12] != 2'd0);
    mem_cmd_ready_i = (a[15:14] != 2'd0);
    if (io_taken)
      io_resp_v_i = 1'b0;
    if (!io_resp_v_i && io_q.size() > 0 && a[16])
    begin
      io_resp_i = dev_resp(io_q[0]);
      io_resp_v_i = 1'b1;
    end
    if (mem_taken)
      mem_resp_v_i = 1'b0;
    if (!mem_resp_v_i && mem_q.size() > 0 && a[17])
    begin
      mem_resp_i = dev_resp(mem_q[0]);
      mem_resp_v_i = 1'b1;
    end
  endtask

  // Sees what the coming rising edge will transfer
  task automatic observe_cycle();
    cmd_acc = '0;
    io_taken = io_resp_yumi_o;
    mem_taken = mem_resp_yumi_o;
    if (io_taken)
      void'(io_q.pop_front());
    if (mem_taken)
      void'(mem_q.pop_front());
    for (int r = 0; r < num_req_lp; r++)
    begin
      if (req_cmd_v_i[r] && req_cmd_ready_o[r])
      begin
        cmd_acc[r] = 1'b1;
        accept_cmd(r);
      end
    end
    if (!io_cmd_ready_i || !mem_cmd_ready_i)
    begin
      check_eq("io_cmd_v_o", 128'(io_cmd_v_o), 128'(0));
      check_eq("mem_cmd_v_o", 128'(mem_cmd_v_o), 128'(0));
    end
    if (io_cmd_v_o)
    begin
      check_dispatch("io_cmd_o", io_cmd_o, DEST_IO);
      io_q.push_back(io_cmd_o);
    end
    if (mem_cmd_v_o)
    begin
      check_dispatch("mem_cmd_o", mem_cmd_o, DEST_MEM);
      mem_q.push_back(mem_cmd_o);
    end
    for (int r = 0; r < num_req_lp; r++)
      if (req_resp_v_o[r] && req_resp_yumi_i[r])
        check_resp(r);
  endtask

  initial
  begin
    seed = 99945;
    reset_i = 1'b1;
    req_cmd_i = '0;
    req_cmd_v_i = '0;
    req_resp_yumi_i = '0;
    io_cmd_ready_i = 1'b0;
    io_resp_i = '0;
    io_resp_v_i = 1'b0;
    mem_cmd_ready_i = 1'b0;
    mem_resp_i = '0;
    mem_resp_v_i = 1'b0;
    cfg_busy = 1'b0;
    io_taken = 1'b0;
    mem_taken = 1'b0;
    cmd_acc = '0;
    io_stall = 0;
    received = 0;
    for (int r = 0; r < num_req_lp; r++)
    begin
      issued[r] = 0;
      hold_cnt[r] = 0;
    end
    for (int i = 0; i < `UNCORE_CFG_REGS; i++)
      cfg_model[i] = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    // Outputs stay quiet and command buffers empty before any stimulus
    repeat (3)
    begin
      @(negedge clk_i);
      check_eq("req_cmd_ready_o", 128'(req_cmd_ready_o), 128'({num_req_lp{1'b1}}));
      check_eq("req_resp_v_o", 128'(req_resp_v_o), 128'(0));
      check_eq("io_cmd_v_o", 128'(io_cmd_v_o), 128'(0));
      check_eq("mem_cmd_v_o", 128'(mem_cmd_v_o), 128'(0));
      check_eq("io_resp_yumi_o", 128'(io_resp_yumi_o), 128'(0));
      check_eq("mem_resp_yumi_o", 128'(mem_resp_yumi_o), 128'(0));
    end
    while (received < num_req_lp * cmds_lp)
    begin
      @(negedge clk_i);
      drive_inputs();
      #1;
      observe_cycle();
    end
    @(negedge clk_i);
    req_resp_yumi_i = '0;
    io_resp_v_i = 1'b0;
    mem_resp_v_i = 1'b0;
    repeat (10) @(negedge clk_i);
    if (req_resp_v_o == '0 && !io_cmd_v_o && !mem_cmd_v_o && io_q.size() == 0
        && mem_q.size() == 0)
    begin
      $display("Test passed");
      $finish;
    end
    else
      abort_run("Extra traffic appeared after the last expected response");
  end

  initial
  begin
    #(timeout_cycles_lp * 10);
    abort_run($sformatf("Timeout with only %0d of %0d responses received",
                        received, num_req_lp * cmds_lp));
  end

endmodule

// ==== verification/uncore_assertions.sv ====
`timescale 1ns/1ns
`include "uncore_cfg.svh"

module uncore_assertions
  (input                           clk_i
   , input                         reset_i
   , input [`UNCORE_NUM_REQ-1:0]   head_v_i
   , input [`UNCORE_NUM_REQ-1:0]   head_yumi_i
   , input                         io_cmd_v_i
   , input                         mem_cmd_v_i
   , input                         local_v_i
   , input [`UNCORE_NUM_REQ-1:0]   resp_v_i
   , input [`UNCORE_NUM_REQ-1:0]   resp_yumi_i
   , input                         io_resp_v_i
   , input                         io_resp_yumi_i
   , input                         mem_resp_v_i
   , input                         mem_resp_yumi_i
   );

  // A grant lights exactly one destination valid
  a_one_dest: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({io_cmd_v_i, mem_cmd_v_i, local_v_i})
    && ((|head_yumi_i) == (io_cmd_v_i | mem_cmd_v_i | local_v_i)))
    else $error("Destination valid does not match a single grant");

  a_yumi_with_v: assert property (@(posedge clk_i) disable iff (reset_i)
    ((head_yumi_i & ~head_v_i) == '0) && ((resp_yumi_i & ~resp_v_i) == '0)
    && (!io_resp_yumi_i || io_resp_v_i) && (!mem_resp_yumi_i || mem_resp_v_i))
    else $error("Yumi raised without valid");

  a_quiet_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (resp_v_i == '0) && !io_cmd_v_i && !mem_cmd_v_i)
    else $error("Valid output high in the cycle after reset");

endmodule

bind uncore_top uncore_assertions u_uncore_assertions
  (.clk_i(clk_i), .reset_i(reset_i), .head_v_i(cmd_head_v), .head_yumi_i(cmd_head_yumi)
   , .io_cmd_v_i(io_cmd_v_o), .mem_cmd_v_i(mem_cmd_v_o), .local_v_i(local_v)
   , .resp_v_i(req_resp_v_o), .resp_yumi_i(req_resp_yumi_i)
   , .io_resp_v_i(io_resp_v_i), .io_resp_yumi_i(io_resp_yumi_o)
   , .mem_resp_v_i(mem_resp_v_i), .mem_resp_yumi_i(mem_resp_yumi_o));

// ==== logic/uncore_top.sv ====
`timescale 1ns/1ns
`include "uncore_cfg.svh"

module uncore_top
  import uncore_msg_pkg::*;
  import uncore_map_pkg::*;
  (input                                   clk_i
   , input                                 reset_i

   , input mem_msg_s [`UNCORE_NUM_REQ-1:0]  req_cmd_i
   , input [`UNCORE_NUM_REQ-1:0]            req_cmd_v_i
   , output logic [`UNCORE_NUM_REQ-1:0]     req_cmd_ready_o

   , output mem_msg_s [`UNCORE_NUM_REQ-1:0] req_resp_o
   , output logic [`UNCORE_NUM_REQ-1:0]     req_resp_v_o
   , input [`UNCORE_NUM_REQ-1:0]            req_resp_yumi_i

   , output mem_msg_s                      io_cmd_o
   , output logic                          io_cmd_v_o
   , input                                 io_cmd_ready_i
   , input mem_msg_s                       io_resp_i
   , input                                 io_resp_v_i
   , output logic                          io_resp_yumi_o

   , output mem_msg_s                      mem_cmd_o
   , output logic                          mem_cmd_v_o
   , input                                 mem_cmd_ready_i
   , input mem_msg_s                       mem_resp_i
   , input                                 mem_resp_v_i
   , output logic                          mem_resp_yumi_o
   );

  mem_msg_s [`UNCORE_NUM_REQ-1:0] cmd_head;
  logic [`UNCORE_NUM_REQ-1:0] cmd_head_v, cmd_head_yumi;
  mem_msg_s resp_buf_li;
  logic [`UNCORE_NUM_REQ-1:0] resp_buf_v_li, resp_buf_ready_lo;

  mem_msg_s cmd_sel, local_resp;
  logic local_v, local_ready, local_resp_v, local_resp_yumi;
  dest_e local_dest;

  for (genvar i = 0; i < `UNCORE_NUM_REQ; i++)
  begin : buffers
    two_fifo #(.width_p($bits(mem_msg_s))) u_cmd_fifo
      (.clk_i(clk_i), .reset_i(reset_i)
       , .data_i(req_cmd_i[i]), .v_i(req_cmd_v_i[i]), .ready_o(req_cmd_ready_o[i])
       , .data_o(cmd_head[i]), .v_o(cmd_head_v[i]), .yumi_i(cmd_head_yumi[i]));

    two_fifo #(.width_p($bits(mem_msg_s))) u_resp_fifo
      (.clk_i(clk_i), .reset_i(reset_i)
       , .data_i(resp_buf_li), .v_i(resp_buf_v_li[i]), .ready_o(resp_buf_ready_lo[i])
       , .data_o(req_resp_o[i]), .v_o(req_resp_v_o[i]), .yumi_i(req_resp_yumi_i[i]));
  end

  cmd_router u_cmd_router
    (.head_i(cmd_head), .head_v_i(cmd_head_v), .head_yumi_o(cmd_head_yumi)
     , .cmd_o(cmd_sel)
     , .io_v_o(io_cmd_v_o), .io_ready_i(io_cmd_ready_i)
     , .mem_v_o(mem_cmd_v_o), .mem_ready_i(mem_cmd_ready_i)
     , .local_v_o(local_v), .local_dest_o(local_dest), .local_ready_i(local_ready));

  // One selected command fans out to every destination
  assign io_cmd_o = cmd_sel;
  assign mem_cmd_o = cmd_sel;

  local_slave u_local_slave
    (.clk_i(clk_i), .reset_i(reset_i)
     , .cmd_i(cmd_sel), .cmd_v_i(local_v), .dest_i(local_dest), .ready_o(local_ready)
     , .resp_o(local_resp), .resp_v_o(local_resp_v), .resp_yumi_i(local_resp_yumi));

  resp_router u_resp_router
    (.local_i(local_resp), .local_v_i(local_resp_v), .local_yumi_o(local_resp_yumi)
     , .mem_i(mem_resp_i), .mem_v_i(mem_resp_v_i), .mem_yumi_o(mem_resp_yumi_o)
     , .io_i(io_resp_i), .io_v_i(io_resp_v_i), .io_yumi_o(io_resp_yumi_o)
     , .buf_o(resp_buf_li), .buf_v_o(resp_buf_v_li), .buf_ready_i(resp_buf_ready_lo));

endmodule

// ==== logic/resp_router.sv ====
`timescale 1ns/1ns
`include "uncore_cfg.svh"

module resp_router
  import uncore_msg_pkg::*;
  (input mem_msg_s                      local_i
   , input                              local_v_i
   , output logic                       local_yumi_o

   , input mem_msg_s                    mem_i
   , input                              mem_v_i
   , output logic                       mem_yumi_o

   , input mem_msg_s                    io_i
   , input                              io_v_i
   , output logic                       io_yumi_o

   , output mem_msg_s                   buf_o
   , output logic [`UNCORE_NUM_REQ-1:0] buf_v_o
   , input [`UNCORE_NUM_REQ-1:0]        buf_ready_i
   );

  logic all_ready, any_grant;

  // Collect only when every response buffer has room
  assign all_ready = &buf_ready_i;

  assign local_yumi_o = all_ready & local_v_i;
  assign mem_yumi_o = all_ready & mem_v_i & ~local_v_i;
  assign io_yumi_o = all_ready & io_v_i & ~local_v_i & ~mem_v_i;

  assign any_grant = local_yumi_o | mem_yumi_o | io_yumi_o;

  always_comb
  begin
    if (local_v_i)
      buf_o = local_i;
    else if (mem_v_i)
      buf_o = mem_i;
    else
      buf_o = io_i;
  end

  // Steer by requester id; id 3 matches no buffer and is dropped
  always_comb
  begin
    buf_v_o = '0;
    for (int i = 0; i < `UNCORE_NUM_REQ; i++)
      buf_v_o[i] = any_grant & (buf_o.id == req_id_t'(i));
  end

endmodule

// ==== logic/local_slave.sv ====
`timescale 1ns/1ns
`include "uncore_cfg.svh"

module local_slave
  import uncore_msg_pkg::*;
  import uncore_map_pkg::*;
  (input              clk_i
   , input            reset_i

   , input mem_msg_s  cmd_i
   , input            cmd_v_i
   , input dest_e     dest_i
   , output logic     ready_o

   , output mem_msg_s resp_o
   , output logic     resp_v_o
   , input            resp_yumi_i
   );

  localparam int idx_w_lp = $clog2(`UNCORE_CFG_REGS);

  data_t cfg_r [`UNCORE_CFG_REGS];
  mem_msg_s resp_r;
  logic resp_v_r;
  logic accept, is_cfg;
  logic [idx_w_lp-1:0] idx;

  assign ready_o = ~resp_v_r;
  assign accept = cmd_v_i & ready_o;
  assign is_cfg = (dest_i == DEST_CFG);
  assign idx = cmd_i.addr[3 +: idx_w_lp];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_v_r <= 1'b0;
      for (int i = 0; i < `UNCORE_CFG_REGS; i++)
        cfg_r[i] <= '0;
    end
    else
    begin
      if (accept)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
      if (accept & is_cfg & (cmd_i.op == MSG_WR))
        cfg_r[idx] <= cmd_i.data;
    end
  end

  // Writes and loopback reads answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r.op <= cmd_i.op;
      resp_r.id <= cmd_i.id;
      resp_r.addr <= cmd_i.addr;
      resp_r.data <= (is_cfg & (cmd_i.op == MSG_RD)) ? cfg_r[idx] : '0;
    end
  end

  assign resp_o = resp_r;
  assign resp_v_o = resp_v_r;

endmodule

// ==== logic/cmd_router.sv ====
`timescale 1ns/1ns
`include "uncore_cfg.svh"

module cmd_router
  import uncore_msg_pkg::*;
  import uncore_map_pkg::*;
  (input mem_msg_s [`UNCORE_NUM_REQ-1:0] head_i
   , input [`UNCORE_NUM_REQ-1:0]          head_v_i
   , output logic [`UNCORE_NUM_REQ-1:0]   head_yumi_o

   , output mem_msg_s                     cmd_o
   , output logic                         io_v_o
   , input                                io_ready_i
   , output logic                         mem_v_o
   , input                                mem_ready_i
   , output logic                         local_v_o
   , output dest_e                        local_dest_o
   , input                                local_ready_i
   );

  logic all_ready, any_grant;
  logic [$bits(mem_msg_s)-1:0] sel_bits;
  logic other_domain, is_local;
  dev_id_t dev;
  dest_e dest;

  // A stalled destination blocks every requester
  assign all_ready = io_ready_i & mem_ready_i & local_ready_i;

  // Highest index wins, so I/O beats data beats instruction
  always_comb
  begin
    head_yumi_o = '0;
    sel_bits = '0;
    for (int i = 0; i < `UNCORE_NUM_REQ; i++)
    begin
      if (all_ready & head_v_i[i])
        head_yumi_o = `UNCORE_NUM_REQ'(1) << i;
    end
    for (int i = 0; i < `UNCORE_NUM_REQ; i++)
      sel_bits = sel_bits | (head_i[i] & {$bits(mem_msg_s){head_yumi_o[i]}});
  end

  assign cmd_o = mem_msg_s'(sel_bits);
  assign any_grant = |head_yumi_o;

  assign other_domain = |cmd_o.addr[`UNCORE_PADDR_W-1 -: `UNCORE_DID_W];
  assign is_local = (cmd_o.addr < `UNCORE_DRAM_BASE);
  assign dev = cmd_o.addr[`UNCORE_DEV_LSB +: $bits(dev_id_t)];

  always_comb
  begin
    if (other_domain)
      dest = DEST_IO;
    else if (!is_local)
      dest = DEST_MEM;
    else
    begin
      case (dev)
        DEV_BOOT, DEV_HOST, DEV_SD: dest = DEST_IO;
        DEV_CACHE:                  dest = DEST_MEM;
        DEV_CFG:                    dest = DEST_CFG;
        default:                    dest = DEST_LOOP;
      endcase
    end
  end

  assign io_v_o = any_grant & (dest == DEST_IO);
  assign mem_v_o = any_grant & (dest == DEST_MEM);
  assign local_v_o = any_grant & ((dest == DEST_CFG) | (dest == DEST_LOOP));
  assign local_dest_o = dest;

endmodule

// ==== logic/two_fifo.sv ====
`timescale 1ns/1ns
`include "uncore_cfg.svh"

module two_fifo
  #(parameter int width_p = 8)
  (input                      clk_i
   , input                    reset_i

   , input [width_p-1:0]      data_i
   , input                    v_i
   , output logic             ready_o

   , output logic [width_p-1:0] data_o
   , output logic             v_o
   , input                    yumi_i
   );

  localparam int ptr_w_lp = $clog2(`UNCORE_FIFO_DEPTH);

  logic [width_p-1:0] mem_r [`UNCORE_FIFO_DEPTH];
  logic [ptr_w_lp-1:0] wptr_r, rptr_r;
  logic full_r;
  logic enq, deq;

  assign enq = v_i & ~full_r;
  assign deq = yumi_i;

  assign ready_o = ~full_r;
  assign v_o = full_r | (wptr_r != rptr_r);
  assign data_o = mem_r[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
      full_r <= 1'b0;
    end
    else
    begin
      if (enq)
        wptr_r <= wptr_r + 1'b1;
      if (deq)
        rptr_r <= rptr_r + 1'b1;
      // Full only when a lone write catches up with the read pointer
      if (enq & ~deq)
        full_r <= (ptr_w_lp'(wptr_r + 1'b1) == rptr_r);
      else if (deq & ~enq)
        full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

endmodule

// ==== logic/uncore_map_pkg.sv ====
package uncore_map_pkg;

  // Device field below the DRAM base
  typedef logic [3:0] dev_id_t;

  typedef enum dev_id_t
  {
    DEV_BOOT  = 4'd0,
    DEV_HOST  = 4'd1,
    DEV_CFG   = 4'd2,
    DEV_CLINT = 4'd3,
    DEV_CACHE = 4'd4,
    DEV_SD    = 4'd5
  } dev_e;

  typedef enum logic [1:0]
  {
    DEST_IO   = 2'd0,
    DEST_MEM  = 2'd1,
    DEST_CFG  = 2'd2,
    DEST_LOOP = 2'd3
  } dest_e;

endpackage

// ==== logic/uncore_msg_pkg.sv ====
`include "uncore_cfg.svh"

package uncore_msg_pkg;

  typedef logic [`UNCORE_PADDR_W-1:0] paddr_t;
  typedef logic [`UNCORE_DATA_W-1:0] data_t;
  typedef logic [`UNCORE_ID_W-1:0] req_id_t;

  typedef enum logic
  {
    MSG_RD = 1'b0,
    MSG_WR = 1'b1
  } msg_op_e;

  // Command and response share one format
  typedef struct packed
  {
    msg_op_e op;
    req_id_t id;
    paddr_t addr;
    data_t data;
  } mem_msg_s;

endpackage

// ==== logic/uncore_cfg.svh ====
`ifndef UNCORE_CFG_SVH
`define UNCORE_CFG_SVH

// Message field widths
`define UNCORE_PADDR_W 40
`define UNCORE_DATA_W 64
`define UNCORE_NUM_REQ 3
`define UNCORE_ID_W 2

// Slots in each command and response buffer
`define UNCORE_FIFO_DEPTH 2

// Address map
`define UNCORE_DRAM_BASE 40'h00_8000_0000
`define UNCORE_DEV_LSB 20
`define UNCORE_DID_W 7
`define UNCORE_CFG_REGS 8

`endif
